//--- source/isa_pkg.sv
package isa_pkg;

    //////////////////////////////
    // widths and vector types
    //////////////////////////////
    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int IMM_W    = 16;
    localparam int JIDX_W   = 26;
    localparam int OP_W     = 6;
    localparam int FUNC_W   = 6;
    localparam int ALU_OP_W = 12;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [REG_W-1:0]    reg_addr_t;
    typedef logic [IMM_W-1:0]    imm_t;
    typedef logic [ALU_OP_W-1:0] alu_op_t;   // one-hot

    // instruction field positions (low bit)
    localparam int OP_POS   = 26;
    localparam int RS_POS   = 21;
    localparam int RT_POS   = 16;
    localparam int RD_POS   = 11;
    localparam int FUNC_POS = 0;
    localparam int IMM_POS  = 0;
    localparam int JIDX_POS = 0;

    // alu select bits
    localparam int ALU_ADD = 0;
    localparam int ALU_SUB = 1;
    localparam int ALU_AND = 4;
    localparam int ALU_OR  = 6;
    localparam int ALU_LUI = 11;

    //////////////////////////////
    // opcodes and function codes
    //////////////////////////////
    localparam logic [OP_W-1:0] OP_SPECIAL = 6'h00;
    localparam logic [OP_W-1:0] OP_J       = 6'h02;
    localparam logic [OP_W-1:0] OP_JAL     = 6'h03;
    localparam logic [OP_W-1:0] OP_BEQ     = 6'h04;
    localparam logic [OP_W-1:0] OP_BNE     = 6'h05;
    localparam logic [OP_W-1:0] OP_ADDIU   = 6'h09;
    localparam logic [OP_W-1:0] OP_LUI     = 6'h0f;
    localparam logic [OP_W-1:0] OP_LW      = 6'h23;
    localparam logic [OP_W-1:0] OP_SW      = 6'h2b;

    localparam logic [FUNC_W-1:0] FN_JR   = 6'h08;
    localparam logic [FUNC_W-1:0] FN_ADDU = 6'h21;
    localparam logic [FUNC_W-1:0] FN_SUBU = 6'h23;
    localparam logic [FUNC_W-1:0] FN_AND  = 6'h24;
    localparam logic [FUNC_W-1:0] FN_OR   = 6'h25;

    localparam reg_addr_t REG_LINK = 5'd31;  // jal writes here
    localparam int        NUM_REGS = 32;

endpackage

//--- source/pipe_pkg.sv
package pipe_pkg;

    // bypass order is 0 execute, 1 memory, 2 writeback
    localparam int NUM_BYPASS = 3;
    // source order is 0 rs, 1 rt
    localparam int NUM_SRC    = 2;

    //////////////////////////////
    // decode to execute bus
    //////////////////////////////
    localparam int DS_TO_ES_BUS_WD = 135;

    typedef logic [DS_TO_ES_BUS_WD-1:0] ds_to_es_bus_t;

    // low bit of each field
    localparam int BUS_PC_LSB          = 0;
    localparam int BUS_RT_VALUE_LSB    = 32;
    localparam int BUS_RS_VALUE_LSB    = 64;
    localparam int BUS_IMM_LSB         = 96;
    localparam int BUS_DEST_LSB        = 112;
    localparam int BUS_MEM_WE_LSB      = 117;
    localparam int BUS_GR_WE_LSB       = 118;
    localparam int BUS_SRC2_IS_8_LSB   = 119;
    localparam int BUS_SRC2_IS_IMM_LSB = 120;
    localparam int BUS_SRC1_IS_PC_LSB  = 121;
    localparam int BUS_LOAD_OP_LSB     = 122;
    localparam int BUS_ALU_OP_LSB      = 123;   // up to bit 134

endpackage

//--- source/bypass_if.sv
`timescale 1ns/1ps

// pending register write of one later stage
interface bypass_if import isa_pkg::*; ();

    logic      valid;
    reg_addr_t dest;
    word_t     data;
    logic      is_load;   // data not ready yet

    modport stage (
        output valid, dest, data, is_load
    );

    modport sel (
        input valid, dest, data, is_load
    );

endinterface

//--- source/regfile.sv
`timescale 1ns/1ps

module regfile import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr [NUM_SRC],
    output word_t     rdata [NUM_SRC],
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t mem [NUM_REGS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // async read, r0 hardwired to zero
    for (genvar i = 0; i < NUM_SRC; i++) begin : g_rd
        assign rdata[i] = (raddr[i] == '0) ? '0 : mem[raddr[i]];
    end

endmodule

//--- source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
    input  word_t     inst,
    output alu_op_t   alu_op,
    output logic      load_op,
    output logic      src1_is_pc,
    output logic      src2_is_imm,
    output logic      src2_is_8,
    output logic      gr_we,
    output logic      mem_we,
    output reg_addr_t dest,
    output imm_t      imm,
    output reg_addr_t src_addr [NUM_SRC],
    output logic      is_beq,
    output logic      is_bne,
    output logic      is_j,
    output logic      is_jal,
    output logic      is_jr
);

    logic [OP_W-1:0]   op;
    logic [FUNC_W-1:0] func;
    reg_addr_t         rs;
    reg_addr_t         rt;
    reg_addr_t         rd;
    logic              special;

    logic inst_addu;
    logic inst_subu;
    logic inst_and;
    logic inst_or;
    logic inst_addiu;
    logic inst_lui;
    logic inst_lw;
    logic inst_sw;

    assign op   = inst[OP_POS +: OP_W];
    assign func = inst[FUNC_POS +: FUNC_W];
    assign rs   = inst[RS_POS +: REG_W];
    assign rt   = inst[RT_POS +: REG_W];
    assign rd   = inst[RD_POS +: REG_W];
    assign imm  = inst[IMM_POS +: IMM_W];

    //////////////////////////////
    // instruction match
    //////////////////////////////
    assign special    = (op == OP_SPECIAL);
    assign inst_addu  = special && (func == FN_ADDU);
    assign inst_subu  = special && (func == FN_SUBU);
    assign inst_and   = special && (func == FN_AND);
    assign inst_or    = special && (func == FN_OR);
    assign is_jr      = special && (func == FN_JR);
    assign inst_addiu = (op == OP_ADDIU);
    assign inst_lui   = (op == OP_LUI);
    assign inst_lw    = (op == OP_LW);
    assign inst_sw    = (op == OP_SW);
    assign is_beq     = (op == OP_BEQ);
    assign is_bne     = (op == OP_BNE);
    assign is_j       = (op == OP_J);
    assign is_jal     = (op == OP_JAL);

    always_comb begin
        alu_op          = '0;   // unknown ops stay all zero
        alu_op[ALU_ADD] = inst_addu | inst_addiu | inst_lw | inst_sw | is_jal;
        alu_op[ALU_SUB] = inst_subu;
        alu_op[ALU_AND] = inst_and;
        alu_op[ALU_OR]  = inst_or;
        alu_op[ALU_LUI] = inst_lui;
    end

    assign load_op     = inst_lw;
    assign mem_we      = inst_sw;
    assign src1_is_pc  = is_jal;   // link value is pc + 8
    assign src2_is_8   = is_jal;
    assign src2_is_imm = inst_addiu | inst_lui | inst_lw | inst_sw;
    assign gr_we       = inst_addu | inst_subu | inst_and | inst_or
                       | inst_addiu | inst_lui | inst_lw | is_jal;

    assign dest = is_jal                            ? REG_LINK :
                  (inst_addiu | inst_lui | inst_lw) ? rt       :
                                                      rd;

    assign src_addr[0] = rs;
    assign src_addr[1] = rt;

endmodule

//--- source/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import isa_pkg::*, pipe_pkg::*; (
    input  reg_addr_t src,
    input  word_t     rf_data,
    bypass_if.sel     fwd [NUM_BYPASS],
    output word_t     value
);

    logic [NUM_BYPASS-1:0] hit;
    word_t                 fwd_data [NUM_BYPASS];

    for (genvar i = 0; i < NUM_BYPASS; i++) begin : g_match
        assign hit[i]      = fwd[i].valid && (fwd[i].dest == src);
        assign fwd_data[i] = fwd[i].data;
    end

    // walk from oldest to newest so the youngest match wins
    always_comb begin
        value = rf_data;
        for (int k = NUM_BYPASS - 1; k >= 0; k--) begin
            if (hit[k]) begin
                value = fwd_data[k];
            end
        end
    end

endmodule

//--- source/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import isa_pkg::*; (
    input  word_t             pc,
    input  imm_t              imm,
    input  logic [JIDX_W-1:0] jidx,
    input  logic              is_beq,
    input  logic              is_bne,
    input  logic              is_j,
    input  logic              is_jal,
    input  logic              is_jr,
    input  word_t             rs_value,
    input  word_t             rt_value,
    output logic              taken,
    output word_t             target
);

    word_t seq_pc;
    word_t br_offset;
    logic  rs_eq_rt;
    logic  is_cond;

    assign seq_pc    = pc + 32'd4;   // delay slot pc
    assign br_offset = {{(WORD_W - IMM_W - 2){imm[IMM_W-1]}}, imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);
    assign is_cond   = is_beq | is_bne;

    assign taken = (is_beq && rs_eq_rt)
                || (is_bne && !rs_eq_rt)
                || is_j
                || is_jal
                || is_jr;

    // j/jal stay inside the 256 MB region of the slot
    assign target = is_cond ? seq_pc + br_offset :
                    is_jr   ? rs_value           :
                              {seq_pc[WORD_W-1 -: 4], jidx, 2'b00};

endmodule

//--- source/id_stage.sv
`timescale 1ns/1ps

module id_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          fs_to_ds_valid,
    input  word_t         fs_pc,
    input  word_t         fs_inst,
    input  logic          es_allowin,
    output logic          ds_allowin,
    output logic          ds_to_es_valid,
    output ds_to_es_bus_t ds_to_es_bus,
    output logic          br_taken,
    output word_t         br_target,
    input  logic          rf_we,
    input  reg_addr_t     rf_waddr,
    input  word_t         rf_wdata,
    input  logic          es_fwd_valid,
    input  reg_addr_t     es_fwd_dest,
    input  word_t         es_fwd_data,
    input  logic          es_fwd_is_load,
    input  logic          ms_fwd_valid,
    input  reg_addr_t     ms_fwd_dest,
    input  word_t         ms_fwd_data,
    input  logic          ms_fwd_is_load,
    input  logic          ws_fwd_valid,
    input  reg_addr_t     ws_fwd_dest,
    input  word_t         ws_fwd_data
);

    logic      ds_valid;
    word_t     ds_pc;
    word_t     ds_inst;
    logic      stall;
    logic      ds_ready_go;

    alu_op_t   alu_op;
    logic      load_op;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      src2_is_8;
    logic      gr_we;
    logic      mem_we;
    reg_addr_t dest;
    imm_t      imm;
    logic      is_beq;
    logic      is_bne;
    logic      is_j;
    logic      is_jal;
    logic      is_jr;
    logic      taken;

    reg_addr_t src_addr  [NUM_SRC];
    word_t     rf_rdata  [NUM_SRC];
    word_t     src_value [NUM_SRC];

    //////////////////////////////
    // stage register
    //////////////////////////////
    assign stall          = fwd[0].is_load | fwd[1].is_load;  // load result not back yet
    assign ds_ready_go    = ~stall;
    assign ds_allowin     = ~ds_valid | (ds_ready_go & es_allowin);
    assign ds_to_es_valid = ds_valid & ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    //////////////////////////////
    // bypass sources
    //////////////////////////////
    bypass_if fwd [NUM_BYPASS] ();   // 0 es, 1 ms, 2 ws

    assign fwd[0].valid   = es_fwd_valid;
    assign fwd[0].dest    = es_fwd_dest;
    assign fwd[0].data    = es_fwd_data;
    assign fwd[0].is_load = es_fwd_is_load;
    assign fwd[1].valid   = ms_fwd_valid;
    assign fwd[1].dest    = ms_fwd_dest;
    assign fwd[1].data    = ms_fwd_data;
    assign fwd[1].is_load = ms_fwd_is_load;
    assign fwd[2].valid   = ws_fwd_valid;
    assign fwd[2].dest    = ws_fwd_dest;
    assign fwd[2].data    = ws_fwd_data;
    assign fwd[2].is_load = 1'b0;        // writeback data is final

    inst_decoder u_dec (
        .inst        (ds_inst),
        .alu_op      (alu_op),
        .load_op     (load_op),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .src2_is_8   (src2_is_8),
        .gr_we       (gr_we),
        .mem_we      (mem_we),
        .dest        (dest),
        .imm         (imm),
        .src_addr    (src_addr),
        .is_beq      (is_beq),
        .is_bne      (is_bne),
        .is_j        (is_j),
        .is_jal      (is_jal),
        .is_jr       (is_jr)
    );

    regfile u_regfile (
        .clk   (clk),
        .raddr (src_addr),
        .rdata (rf_rdata),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata)
    );

    for (genvar i = 0; i < NUM_SRC; i++) begin : g_src
        operand_bypass u_bypass (
            .src     (src_addr[i]),
            .rf_data (rf_rdata[i]),
            .fwd     (fwd),
            .value   (src_value[i])
        );
    end

    branch_unit u_branch (
        .pc       (ds_pc),
        .imm      (imm),
        .jidx     (ds_inst[JIDX_POS +: JIDX_W]),
        .is_beq   (is_beq),
        .is_bne   (is_bne),
        .is_j     (is_j),
        .is_jal   (is_jal),
        .is_jr    (is_jr),
        .rs_value (src_value[0]),
        .rt_value (src_value[1]),
        .taken    (taken),
        .target   (br_target)
    );

    assign br_taken = taken & ds_valid;

    assign ds_to_es_bus = {
        alu_op,        // 134:123
        load_op,
        src1_is_pc,
        src2_is_imm,
        src2_is_8,
        gr_we,
        mem_we,        // 117
        dest,          // 116:112
        imm,
        src_value[0],  // rs
        src_value[1],  // rt
        ds_pc          // 31:0
    };

endmodule

//--- sim/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

//////////////////////////////
// decode rules
//////////////////////////////

// flags are {load_op, src1_is_pc, src2_is_imm, src2_is_8, gr_we, mem_we}
function automatic logic [ALU_OP_W+5:0] pack_ctrl(input int alu_bit, input logic [5:0] flags);
    alu_op_t alu;
    alu = '0;
    alu[alu_bit] = 1'b1;
    return {alu, flags};
endfunction

function automatic ds_to_es_bus_t decode_bus(input word_t inst, input word_t pc,
                                             input word_t rs_v, input word_t rt_v);
    ds_to_es_bus_t         bus;
    logic [ALU_OP_W+5:0]   ctrl;
    reg_addr_t             dest;
    logic [OP_W-1:0]       op;
    op   = inst[OP_POS +: OP_W];
    ctrl = '0;   // outside the subset
    case (op)
        OP_SPECIAL: begin
            case (inst[FUNC_POS +: FUNC_W])
                FN_ADDU: ctrl = pack_ctrl(ALU_ADD, 6'b000010);
                FN_SUBU: ctrl = pack_ctrl(ALU_SUB, 6'b000010);
                FN_AND:  ctrl = pack_ctrl(ALU_AND, 6'b000010);
                FN_OR:   ctrl = pack_ctrl(ALU_OR, 6'b000010);
                default: ctrl = '0;   // jr and unknown
            endcase
        end
        OP_ADDIU: ctrl = pack_ctrl(ALU_ADD, 6'b001010);
        OP_LUI:   ctrl = pack_ctrl(ALU_LUI, 6'b001010);
        OP_LW:    ctrl = pack_ctrl(ALU_ADD, 6'b101010);
        OP_SW:    ctrl = pack_ctrl(ALU_ADD, 6'b001001);
        OP_JAL:   ctrl = pack_ctrl(ALU_ADD, 6'b010110);
        default:  ctrl = '0;
    endcase
    case (op)
        OP_JAL:                  dest = REG_LINK;
        OP_ADDIU, OP_LUI, OP_LW: dest = inst[RT_POS +: REG_W];
        default:                 dest = inst[RD_POS +: REG_W];
    endcase
    bus = '0;
    bus[BUS_MEM_WE_LSB +: ALU_OP_W+6] = ctrl;
    bus[BUS_DEST_LSB +: REG_W]        = dest;
    bus[BUS_IMM_LSB +: IMM_W]         = inst[IMM_POS +: IMM_W];
    bus[BUS_RS_VALUE_LSB +: WORD_W]   = rs_v;
    bus[BUS_RT_VALUE_LSB +: WORD_W]   = rt_v;
    bus[BUS_PC_LSB +: WORD_W]         = pc;
    return bus;
endfunction

//////////////////////////////
// operands, stall, branch
//////////////////////////////
function automatic word_t forward_operand(input reg_addr_t src);
    if (es_fwd_valid && es_fwd_dest == src) return es_fwd_data;
    if (ms_fwd_valid && ms_fwd_dest == src) return ms_fwd_data;
    if (ws_fwd_valid && ws_fwd_dest == src) return ws_fwd_data;
    if (src == '0) return '0;
    return regs[src];
endfunction

function automatic logic load_stall(input logic es_load, input logic ms_load);
    return es_load | ms_load;   // addresses do not matter
endfunction

function automatic logic resolve_taken(input word_t inst, input word_t rs_v, input word_t rt_v);
    case (inst[OP_POS +: OP_W])
        OP_BEQ:       return rs_v == rt_v;
        OP_BNE:       return rs_v != rt_v;
        OP_J, OP_JAL: return 1'b1;
        OP_SPECIAL:   return inst[FUNC_POS +: FUNC_W] == FN_JR;
        default:      return 1'b0;
    endcase
endfunction

function automatic word_t jump_target(input word_t inst, input word_t pc, input word_t rs_v);
    word_t next_pc;
    next_pc = pc + 32'd4;
    case (inst[OP_POS +: OP_W])
        OP_BEQ, OP_BNE: return next_pc + {{14{inst[15]}}, inst[15:0], 2'b00};
        OP_J, OP_JAL:   return {next_pc[31:28], inst[25:0], 2'b00};
        default:        return rs_v;   // jr
    endcase
endfunction

`endif

//--- sim/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage import isa_pkg::*, pipe_pkg::*; ();

    logic          clk;
    logic          reset;
    logic          fs_to_ds_valid;
    word_t         fs_pc;
    word_t         fs_inst;
    logic          es_allowin;
    logic          ds_allowin;
    logic          ds_to_es_valid;
    ds_to_es_bus_t ds_to_es_bus;
    logic          br_taken;
    word_t         br_target;
    logic          rf_we;
    reg_addr_t     rf_waddr;
    word_t         rf_wdata;
    logic          es_fwd_valid;
    reg_addr_t     es_fwd_dest;
    word_t         es_fwd_data;
    logic          es_fwd_is_load;
    logic          ms_fwd_valid;
    reg_addr_t     ms_fwd_dest;
    word_t         ms_fwd_data;
    logic          ms_fwd_is_load;
    logic          ws_fwd_valid;
    reg_addr_t     ws_fwd_dest;
    word_t         ws_fwd_data;

    word_t         regs [NUM_REGS];   // shadow of the rf writes
    logic          model_valid;
    word_t         model_pc;
    word_t         model_inst;
    logic          seen_valid;
    logic          seen_allowin;
    ds_to_es_bus_t seen_bus;
    int            err_value;
    int            err_timeout;

    `include "id_ref_model.svh"

    id_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input logic [DS_TO_ES_BUS_WD-1:0] got,
                                   input logic [DS_TO_ES_BUS_WD-1:0] want);
        err_value++;
        $display("[FAIL] %0t ns: %s got %0h, expected %0h", $time, what, got, want);
    endtask

    function automatic reg_addr_t pick_reg();
        // low registers mostly, so bypass hits are common
        if ($urandom_range(0, 3) == 0) return reg_addr_t'($urandom_range(0, 31));
        return reg_addr_t'($urandom_range(0, 7));
    endfunction

    function automatic word_t random_inst();
        word_t w;
        w = $urandom;
        w[RS_POS +: REG_W] = pick_reg();
        w[RT_POS +: REG_W] = pick_reg();
        w[RD_POS +: REG_W] = pick_reg();
        case ($urandom_range(0, 14))
            0:  {w[31:26], w[5:0]} = {OP_SPECIAL, FN_ADDU};
            1:  {w[31:26], w[5:0]} = {OP_SPECIAL, FN_SUBU};
            2:  {w[31:26], w[5:0]} = {OP_SPECIAL, FN_AND};
            3:  {w[31:26], w[5:0]} = {OP_SPECIAL, FN_OR};
            4:  {w[31:26], w[5:0]} = {OP_SPECIAL, FN_JR};
            5:  w[31:26] = OP_ADDIU;
            6:  w[31:26] = OP_LUI;
            7:  w[31:26] = OP_LW;
            8:  w[31:26] = OP_SW;
            9:  w[31:26] = OP_BEQ;
            10: w[31:26] = OP_BNE;
            11: w[31:26] = OP_J;
            12: w[31:26] = OP_JAL;
            13: {w[31:26], w[5:0]} = {OP_SPECIAL, 6'h2a};   // slt is not kept
            default: w[31:26] = 6'h0c;                     // andi is not kept
        endcase
        return w;
    endfunction

    task automatic quiet_inputs();
        fs_to_ds_valid = 1'b0;
        fs_pc          = '0;
        fs_inst        = '0;
        es_allowin     = 1'b1;
        rf_we          = 1'b0;
        rf_waddr       = '0;
        rf_wdata       = '0;
        {es_fwd_valid, es_fwd_dest, es_fwd_data, es_fwd_is_load} = '0;
        {ms_fwd_valid, ms_fwd_dest, ms_fwd_data, ms_fwd_is_load} = '0;
        {ws_fwd_valid, ws_fwd_dest, ws_fwd_data} = '0;
    endtask

    task automatic drive_random();
        fs_to_ds_valid = ($urandom_range(0, 3) != 0);
        fs_pc          = $urandom & 32'hffff_fffc;
        fs_inst        = random_inst();
        es_allowin     = ($urandom_range(0, 3) != 0);
        rf_we          = $urandom_range(0, 1);
        rf_waddr       = pick_reg();
        rf_wdata       = $urandom;
        es_fwd_valid   = $urandom_range(0, 1);
        es_fwd_dest    = pick_reg();
        es_fwd_data    = $urandom;
        es_fwd_is_load = ($urandom_range(0, 7) == 0);
        ms_fwd_valid   = $urandom_range(0, 1);
        ms_fwd_dest    = pick_reg();
        ms_fwd_data    = $urandom;
        ms_fwd_is_load = ($urandom_range(0, 7) == 0);
        ws_fwd_valid   = $urandom_range(0, 1);
        ws_fwd_dest    = pick_reg();
        ws_fwd_data    = $urandom;
    endtask

    //////////////////////////////
    // per-cycle check and model update
    //////////////////////////////
    task automatic check_outputs();
        logic          allow;
        logic          exp_valid;
        logic          taken;
        word_t         rs_v;
        word_t         rt_v;
        ds_to_es_bus_t bus;
        allow = !model_valid || (!load_stall(es_fwd_is_load, ms_fwd_is_load) && es_allowin);
        exp_valid = model_valid && !load_stall(es_fwd_is_load, ms_fwd_is_load);
        taken = 1'b0;
        assert (ds_allowin === allow) else report_mismatch("ds_allowin", ds_allowin, allow);
        assert (ds_to_es_valid === exp_valid)
            else report_mismatch("ds_to_es_valid", ds_to_es_valid, exp_valid);
        if (model_valid) begin
            rs_v  = forward_operand(model_inst[RS_POS +: REG_W]);
            rt_v  = forward_operand(model_inst[RT_POS +: REG_W]);
            bus   = decode_bus(model_inst, model_pc, rs_v, rt_v);
            taken = resolve_taken(model_inst, rs_v, rt_v);
            assert (ds_to_es_bus === bus) else report_mismatch("ds_to_es_bus", ds_to_es_bus, bus);
            if (taken) begin
                assert (br_target === jump_target(model_inst, model_pc, rs_v))
                    else report_mismatch("br_target", br_target,
                                         jump_target(model_inst, model_pc, rs_v));
            end
        end
        assert (br_taken === taken) else report_mismatch("br_taken", br_taken, taken);
    endtask

    // called 1 ns after an edge, returns 1 ns after the next one
    task automatic step_cycle();
        logic allow;
        #2;
        check_outputs();
        allow        = !model_valid || (!load_stall(es_fwd_is_load, ms_fwd_is_load) && es_allowin);
        seen_valid   = ds_to_es_valid;
        seen_allowin = ds_allowin;
        seen_bus     = ds_to_es_bus;
        @(posedge clk);
        if (reset) begin
            model_valid = 1'b0;
        end else if (allow) begin
            model_valid = fs_to_ds_valid;
        end
        if (allow && fs_to_ds_valid) begin
            model_pc   = fs_pc;
            model_inst = fs_inst;
        end
        if (rf_we) regs[rf_waddr] = rf_wdata;
        #1;
    endtask

    // hold one instruction by a load stall or by back-pressure, then release it
    task automatic hold_test(input logic by_load);
        ds_to_es_bus_t held;
        logic          released;
        quiet_inputs();
        fs_to_ds_valid = 1'b1;
        fs_pc          = $urandom & 32'hffff_fffc;
        fs_inst        = random_inst();
        step_cycle();
        fs_to_ds_valid = 1'b0;
        es_fwd_is_load = by_load;
        es_allowin     = by_load;
        step_cycle();
        held = seen_bus;
        repeat (3) begin
            step_cycle();
            assert (seen_bus === held && !seen_allowin)
                else report_mismatch("held bus", seen_bus, held);
        end
        es_fwd_is_load = 1'b0;
        es_allowin     = 1'b1;
        released       = 1'b0;
        for (int n = 0; n < 8 && !released; n++) begin
            step_cycle();
            released = by_load ? seen_valid : seen_allowin;
        end
        if (!released) begin
            err_timeout++;
            $display("timeout: held instruction was not released within 8 cycles");
        end
        assert (seen_bus === held) else report_mismatch("released bus", seen_bus, held);
    endtask

    initial begin
        void'($urandom(32'h1e18_a8d2));
        err_value   = 0;
        err_timeout = 0;
        model_valid = 1'b0;
        reset       = 1'b1;
        quiet_inputs();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (!ds_to_es_valid && !br_taken && ds_allowin)
            else report_mismatch("state after reset", {ds_to_es_valid, br_taken, ds_allowin}, 1);

        // fill every register so operand reads are known
        for (int r = 0; r < NUM_REGS; r++) begin
            rf_we    = 1'b1;
            rf_waddr = reg_addr_t'(r);
            rf_wdata = $urandom;
            step_cycle();
        end
        rf_we = 1'b0;

        repeat (6) begin
            hold_test(1'b1);
            hold_test(1'b0);
            repeat (500) begin
                drive_random();
                step_cycle();
            end
        end

        $display("errors: %0d value mismatches, %0d timeouts", err_value, err_timeout);
        if (err_value == 0 && err_timeout == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- id_stage.f
+incdir+sim
source/isa_pkg.sv
source/pipe_pkg.sv
source/bypass_if.sv
source/regfile.sv
source/inst_decoder.sv
source/operand_bypass.sv
source/branch_unit.sv
source/id_stage.sv
sim/tb_id_stage.sv
